// ==== verilog/tcdm_pkg.sv ====
// data word and byte-enable definitions shared by the lane interface,
// the wide port adapter, the router and the banks
package tcdm_pkg;

  // bytes per memory word
  localparam int unsigned WordBytes = 4;

  // one memory word, 32 bits
  typedef logic [8*WordBytes-1:0] word_t;

  // one enable bit per byte of a word
  typedef logic [WordBytes-1:0] be_t;

endpackage

// ==== verilog/route_pkg.sv ====
// byte address type and the byte-to-word address mapping
package route_pkg;

  // byte address width of every lane
  localparam int unsigned AddrWidth = 32;

  typedef logic [AddrWidth-1:0] addr_t;

  // low address bits dropped to get the word address
  // word address W -> bank W mod NB_BANKS, row W div NB_BANKS
  localparam int unsigned WordOffsetBits = 2;

endpackage

// ==== verilog/tcdm_lane_intf.sv ====
`timescale 1ns/1ps

// one 32-bit lane of the shared memory, request and response side
interface tcdm_lane_intf;

  logic             req;
  route_pkg::addr_t add;     // byte address
  logic             wen;     // 1 = read, 0 = write
  tcdm_pkg::be_t    be;
  tcdm_pkg::word_t  data;    // write data
  logic             gnt;
  tcdm_pkg::word_t  r_data;  // valid one cycle after the grant

  modport initiator (
    output req,
    output add,
    output wen,
    output be,
    output data,
    input  gnt,
    input  r_data
  );

  modport target (
    input  req,
    input  add,
    input  wen,
    input  be,
    input  data,
    output gnt,
    output r_data
  );

endinterface

// ==== verilog/wide_port_adapter.sv ====
`timescale 1ns/1ps

// splits one wide access into NB_LANES word lanes and
// collects the returned words into a wide read register
module wide_port_adapter #(
  parameter int unsigned NB_LANES = 4
) (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            req_i,
  input  route_pkg::addr_t                                addr_i,
  input  logic                                            wen_i,
  input  logic [NB_LANES-1:0][tcdm_pkg::WordBytes-1:0]    be_i,
  input  tcdm_pkg::word_t [NB_LANES-1:0]                  wdata_i,
  output logic                                            gnt_o,
  output logic                                            r_valid_o,
  output tcdm_pkg::word_t [NB_LANES-1:0]                  r_data_o,
  input  logic                                            r_valid_i,
  tcdm_lane_intf.initiator                                lanes [NB_LANES]
);

  tcdm_pkg::word_t [NB_LANES-1:0] lane_r_data;
  tcdm_pkg::word_t [NB_LANES-1:0] r_data_q;

  for (genvar i = 0; i < NB_LANES; i++) begin : gen_lane
    // lane i goes to word W+i
    assign lanes[i].req  = req_i;
    assign lanes[i].add  = addr_i + route_pkg::addr_t'(i << route_pkg::WordOffsetBits);
    assign lanes[i].wen  = wen_i;
    assign lanes[i].be   = be_i[i];
    assign lanes[i].data = wdata_i[i];

    assign lane_r_data[i] = lanes[i].r_data;
  end

  // router broadcasts one grant, lane 0 is enough
  assign gnt_o = lanes[0].gnt;

  // read words are only valid in the r_valid cycle, keep them until the next read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_data_q <= '0;
    end else if (r_valid_i) begin
      r_data_q <= lane_r_data;
    end
  end

  assign r_valid_o = r_valid_i;
  assign r_data_o  = r_valid_i ? lane_r_data : r_data_q;  // live words in the r_valid cycle

endmodule

// ==== verilog/lane_router_reorder.sv ====
`timescale 1ns/1ps

// rotates the lanes onto the banks by the bank offset of lane 0
// and routes the bank read words back to their lanes
module lane_router_reorder #(
  parameter int unsigned NB_LANES             = 4,
  parameter int unsigned NB_BANKS             = 8,
  parameter int unsigned FILTER_WRITE_R_VALID = 1
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  tcdm_lane_intf.target    lanes [NB_LANES],
  output logic             r_valid_o,
  tcdm_lane_intf.initiator banks [NB_BANKS]
);

  localparam int unsigned BankBits = $clog2(NB_BANKS);

  typedef logic [BankBits-1:0] bank_idx_t;

  route_pkg::addr_t                  word_addr;
  bank_idx_t                         offset;
  bank_idx_t [NB_LANES-1:0]          lane_bank;
  bank_idx_t [NB_LANES-1:0]          lane_bank_q;  // bank that served each lane
  logic [NB_LANES-1:0][NB_BANKS-1:0] ma_req;
  route_pkg::addr_t [NB_LANES-1:0]   lane_add;
  tcdm_pkg::be_t [NB_LANES-1:0]      lane_be;
  tcdm_pkg::word_t [NB_LANES-1:0]    lane_data;
  logic [NB_BANKS-1:0]               touched;
  logic [NB_BANKS-1:0]               bank_gnt;
  tcdm_pkg::word_t [NB_BANKS-1:0]    bank_r_data;
  logic                              lane_req;
  logic                              lane_wen;
  logic                              lane_gnt;
  logic                              accept;
  logic                              r_valid_q;

  // lane 0 carries the request for the whole access
  assign lane_req  = lanes[0].req;
  assign lane_wen  = lanes[0].wen;
  assign word_addr = lanes[0].add >> route_pkg::WordOffsetBits;
  assign offset    = word_addr[BankBits-1:0];

  // all touched banks must be free, otherwise nothing goes out
  assign lane_gnt = &(~touched | bank_gnt);
  assign accept   = lane_req & lane_gnt;

  for (genvar i = 0; i < NB_LANES; i++) begin : gen_lane
    assign lane_bank[i] = offset + bank_idx_t'(i);  // wraps past the last bank

    for (genvar b = 0; b < NB_BANKS; b++) begin : gen_sel
      assign ma_req[i][b] = (lane_bank[i] == bank_idx_t'(b));
    end

    assign lane_add[i]  = lanes[i].add;
    assign lane_be[i]   = lanes[i].be;
    assign lane_data[i] = lanes[i].data;

    assign lanes[i].gnt    = lane_gnt;
    assign lanes[i].r_data = bank_r_data[lane_bank_q[i]];
  end

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    logic             hit;
    route_pkg::addr_t add_m;
    tcdm_pkg::be_t    be_m;
    tcdm_pkg::word_t  data_m;

    // at most one lane selects a bank, so OR-merging is a mux
    always_comb begin
      hit    = 1'b0;
      add_m  = '0;
      be_m   = '0;
      data_m = '0;
      for (int j = 0; j < NB_LANES; j++) begin
        hit    |= ma_req[j][b];
        add_m  |= ma_req[j][b] ? lane_add[j] : '0;
        be_m   |= ma_req[j][b] ? lane_be[j] : '0;
        data_m |= ma_req[j][b] ? lane_data[j] : '0;
      end
    end

    assign touched[b] = lane_req & hit;

    assign banks[b].req  = touched[b] & lane_gnt;
    assign banks[b].add  = add_m;
    assign banks[b].wen  = lane_wen;
    assign banks[b].be   = be_m;
    assign banks[b].data = data_m;

    assign bank_gnt[b]    = banks[b].gnt;
    assign bank_r_data[b] = banks[b].r_data;
  end

  // fixed one-cycle response, writes filtered out unless FILTER_WRITE_R_VALID is 0
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q   <= 1'b0;
      lane_bank_q <= '0;
    end else begin
      r_valid_q <= accept & (lane_wen | (FILTER_WRITE_R_VALID == 0));
      if (accept) begin
        lane_bank_q <= lane_bank;
      end
    end
  end

  assign r_valid_o = r_valid_q;

endmodule

// ==== verilog/tcdm_bank.sv ====
`timescale 1ns/1ps

// single-port word bank with byte enables and one-cycle read latency
module tcdm_bank #(
  parameter int unsigned NB_BANKS   = 8,
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          hold_i,  // bank taken by another master
  tcdm_lane_intf.target port
);

  localparam int unsigned BankBits = $clog2(NB_BANKS);
  localparam int unsigned RowBits  = $clog2(BANK_DEPTH);

  tcdm_pkg::word_t    mem [BANK_DEPTH];
  route_pkg::addr_t   word_addr;
  logic [RowBits-1:0] row;
  logic               access;
  tcdm_pkg::word_t    r_data_q;

  assign port.gnt  = ~hold_i;
  assign word_addr = port.add >> route_pkg::WordOffsetBits;
  assign row       = word_addr[BankBits +: RowBits];  // word address div NB_BANKS
  assign access    = port.req & ~hold_i;

  always_ff @(posedge clk_i) begin
    if (access && !port.wen) begin
      for (int j = 0; j < tcdm_pkg::WordBytes; j++) begin
        if (port.be[j]) begin
          mem[row][8*j +: 8] <= port.data[8*j +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_data_q <= '0;
    end else if (access && port.wen) begin
      r_data_q <= mem[row];
    end
  end

  assign port.r_data = r_data_q;

endmodule

// ==== verilog/wide_tcdm_top.sv ====
`timescale 1ns/1ps

// wide accelerator port on a word-interleaved multi-bank memory
module wide_tcdm_top #(
  parameter int unsigned NB_LANES             = 4,
  parameter int unsigned NB_BANKS             = 8,   // power of two, >= NB_LANES
  parameter int unsigned BANK_DEPTH           = 64,
  parameter int unsigned FILTER_WRITE_R_VALID = 1
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         req_i,
  input  route_pkg::addr_t                             addr_i,
  input  logic                                         wen_i,
  input  logic [NB_LANES-1:0][tcdm_pkg::WordBytes-1:0] be_i,
  input  tcdm_pkg::word_t [NB_LANES-1:0]               wdata_i,
  input  logic [NB_BANKS-1:0]                          bank_hold_i,
  output logic                                         gnt_o,
  output logic                                         r_valid_o,
  output tcdm_pkg::word_t [NB_LANES-1:0]               r_data_o
);

  logic r_valid;

  tcdm_lane_intf lane_if [NB_LANES] ();
  tcdm_lane_intf bank_if [NB_BANKS] ();

  wide_port_adapter #(
    .NB_LANES ( NB_LANES )
  ) wide_port_adapter_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .req_i     ( req_i     ),
    .addr_i    ( addr_i    ),
    .wen_i     ( wen_i     ),
    .be_i      ( be_i      ),
    .wdata_i   ( wdata_i   ),
    .gnt_o     ( gnt_o     ),
    .r_valid_o ( r_valid_o ),
    .r_data_o  ( r_data_o  ),
    .r_valid_i ( r_valid   ),
    .lanes     ( lane_if   )
  );

  lane_router_reorder #(
    .NB_LANES             ( NB_LANES             ),
    .NB_BANKS             ( NB_BANKS             ),
    .FILTER_WRITE_R_VALID ( FILTER_WRITE_R_VALID )
  ) lane_router_reorder_i (
    .clk_i     ( clk_i   ),
    .rst_ni    ( rst_ni  ),
    .lanes     ( lane_if ),
    .r_valid_o ( r_valid ),
    .banks     ( bank_if )
  );

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    tcdm_bank #(
      .NB_BANKS   ( NB_BANKS   ),
      .BANK_DEPTH ( BANK_DEPTH )
    ) tcdm_bank_i (
      .clk_i  ( clk_i          ),
      .rst_ni ( rst_ni         ),
      .hold_i ( bank_hold_i[b] ),
      .port   ( bank_if[b]     )
    );
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/1ps

// clock and power-on reset for the testbench
module tb_clock_gen #(
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // release away from the rising edge
  end

endmodule

// ==== tests/wide_tcdm_checker.sv ====
`timescale 1ns/1ps

// protocol checks on the lane router, bound into lane_router_reorder
module wide_tcdm_checker #(
  parameter int unsigned NB_LANES = 4,
  parameter int unsigned NB_BANKS = 8
) (
  input logic                                      clk_i,
  input logic                                      rst_ni,
  input logic                                      accept_i,
  input logic                                      lane_gnt_i,
  input logic                                      r_valid_i,
  input logic [NB_LANES-1:0][$clog2(NB_BANKS)-1:0] lane_bank_i,
  tcdm_lane_intf.initiator                         banks [NB_BANKS]
);

  typedef logic [NB_LANES-1:0][$clog2(NB_BANKS)-1:0] lane_sel_t;

  logic [NB_BANKS-1:0] bank_req;
  int unsigned         violations = 0;  // polled by the testbench

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_req
    assign bank_req[b] = banks[b].req;
  end

  // no two lanes of one access on the same bank
  function automatic logic lanes_distinct(input lane_sel_t sel);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < NB_LANES; i++) begin
      for (int j = i + 1; j < NB_LANES; j++) begin
        if (sel[i] == sel[j]) ok = 1'b0;
      end
    end
    return ok;
  endfunction

  r_valid_follows_accept: assert property (
    @(posedge clk_i) disable iff (!rst_ni) r_valid_i |-> $past(accept_i)
  ) else begin
    violations = violations + 1;
    $error("r_valid without an accepted request one cycle before");
  end

  no_bank_req_without_gnt: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !lane_gnt_i |-> (bank_req == '0)
  ) else begin
    violations = violations + 1;
    $error("bank request raised while the lane grant is low");
  end

  distinct_lane_banks: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lanes_distinct(lane_bank_i)
  ) else begin
    violations = violations + 1;
    $error("two lanes mapped onto the same bank");
  end

endmodule

bind lane_router_reorder wide_tcdm_checker #(
  .NB_LANES ( NB_LANES ),
  .NB_BANKS ( NB_BANKS )
) router_checker_i (
  .clk_i       ( clk_i     ),
  .rst_ni      ( rst_ni    ),
  .accept_i    ( accept    ),
  .lane_gnt_i  ( lane_gnt  ),
  .r_valid_i   ( r_valid_o ),
  .lane_bank_i ( lane_bank ),
  .banks       ( banks     )
);

// ==== tests/wide_tcdm_tb.sv ====
`timescale 1ns/1ps

module wide_tcdm_tb;

  localparam int unsigned NbLanes    = 4;
  localparam int unsigned NbBanks    = 8;
  localparam int unsigned BankDepth  = 64;
  localparam int unsigned MemWords   = NbBanks * BankDepth;
  localparam int unsigned NumPairs   = 8;  // full-word write then read
  localparam int unsigned NumBePairs = 16;
  localparam int unsigned NumBurst   = 8;
  localparam int unsigned StimCycles = 17 + MemWords / NbLanes + 2 * NumPairs
                                       + 2 * NumBePairs + 6 + NumBurst + 5;
  localparam int unsigned CycleLimit = 2 * StimCycles + 100;

  typedef tcdm_pkg::word_t [NbLanes-1:0]               wide_word_t;
  typedef logic [NbLanes-1:0][tcdm_pkg::WordBytes-1:0] wide_be_t;
  typedef logic [$clog2(NbBanks)-1:0]                  bank_sel_t;
  typedef logic [$clog2(MemWords)-1:0]                 mem_idx_t;

  logic               clk;
  logic               rst_n;
  logic               req;
  route_pkg::addr_t   addr;
  logic               wen;
  wide_be_t           be;
  wide_word_t         wdata;
  logic [NbBanks-1:0] bank_hold;
  logic               gnt;
  logic               r_valid;
  wide_word_t         r_data;
  tcdm_pkg::word_t    ref_mem [MemWords];
  wide_word_t         last_read;  // r_data_o holds this between reads
  int unsigned        cycle_count;

  tb_clock_gen #(.RESET_CYCLES(16)) clock_gen_i (.clk_o(clk), .rst_no(rst_n));

  wide_tcdm_top #(
    .NB_LANES             ( NbLanes   ),
    .NB_BANKS             ( NbBanks   ),
    .BANK_DEPTH           ( BankDepth ),
    .FILTER_WRITE_R_VALID ( 1         )
  ) wide_tcdm_top_i (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .req_i       ( req       ),
    .addr_i      ( addr      ),
    .wen_i       ( wen       ),
    .be_i        ( be        ),
    .wdata_i     ( wdata     ),
    .bank_hold_i ( bank_hold ),
    .gnt_o       ( gnt       ),
    .r_valid_o   ( r_valid   ),
    .r_data_o    ( r_data    )
  );

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    abort_run();
  endtask

  function automatic tcdm_pkg::word_t fill_word(input logic [31:0] w);
    return {w[15:0] ^ 16'h5a5a, ~w[15:0]};
  endfunction

  // gnt_o is expected high when no touched bank is held
  function automatic logic access_free(input int unsigned w, input logic [NbBanks-1:0] hold);
    for (int i = 0; i < NbLanes; i++) begin
      if (hold[bank_sel_t'(w + i)]) return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic wide_word_t rand_words();
    wide_word_t d;
    for (int i = 0; i < NbLanes; i++) d[i] = $urandom;
    return d;
  endfunction

  function automatic int unsigned rand_addr();
    return $urandom % (MemWords - NbLanes + 1);
  endfunction

  // lane 0 near the last bank so the lanes wrap to bank 0
  function automatic int unsigned wrap_addr();
    return NbBanks * ($urandom % (BankDepth - 1)) + NbBanks - 1 - $urandom % (NbLanes - 1);
  endfunction

  // one cycle, called and returning at a falling edge
  task automatic step(input logic rq, input int unsigned w, input logic rd,
                      input wide_be_t b, input wide_word_t d);
    wide_word_t expect_data;
    logic       exp_gnt;
    logic       accepted;
    req   = rq;
    addr  = route_pkg::addr_t'(w << route_pkg::WordOffsetBits);
    wen   = rd;
    be    = b;
    wdata = d;
    exp_gnt = access_free(w, bank_hold);
    @(posedge clk);
    // gnt_o only depends on inputs set at the falling edge
    assert (!rq || gnt == exp_gnt)
      else report_mismatch($sformatf("gnt_o=%0b at word %0d, expected %0b", gnt, w, exp_gnt));
    accepted    = rq && exp_gnt;
    expect_data = last_read;
    for (int i = 0; i < NbLanes; i++) begin
      if (accepted && rd) expect_data[i] = ref_mem[mem_idx_t'(w + i)];
      for (int j = 0; j < tcdm_pkg::WordBytes; j++) begin
        if (accepted && !rd && b[i][j]) ref_mem[mem_idx_t'(w + i)][8*j +: 8] = d[i][8*j +: 8];
      end
    end
    @(negedge clk);
    assert (r_valid == (accepted && rd))
      else report_mismatch($sformatf("r_valid_o=%0b after access at word %0d", r_valid, w));
    last_read = expect_data;
    assert (r_data == last_read)
      else report_mismatch($sformatf("r_data_o=%h, expected %h", r_data, last_read));
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      $display("timeout: the test did not finish within %0d cycles", CycleLimit);
      abort_run();
    end
  end

  always @(negedge clk) begin
    if (wide_tcdm_top_i.lane_router_reorder_i.router_checker_i.violations != 0) begin
      $display("protocol assertion in the router checker failed");
      abort_run();
    end
  end

  initial begin
    wide_word_t  d;
    int unsigned w;
    void'($urandom(32'h201a_1ec7));
    cycle_count = 0;
    req         = 1'b0;
    addr        = '0;
    wen         = 1'b1;
    be          = '0;
    wdata       = '0;
    bank_hold   = '0;
    last_read   = '0;
    @(posedge rst_n);
    assert (!r_valid && r_data == '0 && gnt)
      else report_mismatch("outputs not idle after reset");

    // whole memory gets a known pattern first
    for (int unsigned a = 0; a < MemWords; a += NbLanes) begin
      for (int i = 0; i < NbLanes; i++) d[i] = fill_word(a + i);
      step(1'b1, a, 1'b0, '1, d);
    end

    for (int k = 0; k < NumPairs; k++) begin
      w = k[0] ? wrap_addr() : rand_addr();
      step(1'b1, w, 1'b0, '1, rand_words());
      step(1'b1, w, 1'b1, '0, '0);
    end

    for (int k = 0; k < NumBePairs; k++) begin
      w = (k % 4 == 3) ? wrap_addr() : rand_addr();
      step(1'b1, w, 1'b0, wide_be_t'($urandom), rand_words());
      step(1'b1, w, 1'b1, '0, '0);
    end

    // held bank blocks the whole write
    w = wrap_addr();
    bank_hold[bank_sel_t'(w + 2)] = 1'b1;
    repeat (3) step(1'b1, w, 1'b0, '1, rand_words());
    bank_hold = '0;
    step(1'b1, w, 1'b1, '0, '0);
    bank_hold[bank_sel_t'(w + NbLanes)] = 1'b1;  // untouched bank
    step(1'b1, w, 1'b1, '0, '0);
    bank_hold = '0;

    for (int k = 0; k < NumBurst; k++) step(1'b1, rand_addr(), 1'b1, '0, '0);
    repeat (4) step(1'b1, rand_addr(), 1'b0, wide_be_t'($urandom), rand_words());
    step(1'b0, 0, 1'b1, '0, '0);

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== wide_tcdm_top.f ====
verilog/tcdm_pkg.sv
verilog/route_pkg.sv
verilog/tcdm_lane_intf.sv
verilog/wide_port_adapter.sv
verilog/lane_router_reorder.sv
verilog/tcdm_bank.sv
verilog/wide_tcdm_top.sv
tests/tb_clock_gen.sv
tests/wide_tcdm_checker.sv
tests/wide_tcdm_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the wide TCDM testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module wide_tcdm_tb -f wide_tcdm_top.f -o wide_tcdm_sim

# a failing run may exit nonzero, the log search below decides
./obj_dir/wide_tcdm_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
